// ==== pool_pkg.sv ====
// Shared widths and types for the channel-parallel pooling engine
package pool_pkg;

	// Feature word width, signed two's complement
	localparam int DATA_W = 16;

	// Largest window is 2**MAX_WIN_LOG2 atoms
	localparam int MAX_WIN_LOG2 = 4;

	// Lane accumulator width
	// Extra bits hold a full 16-atom sum without overflow
	localparam int ACC_W = DATA_W + MAX_WIN_LOG2;

	// Reduction applied by every lane to a window
	typedef enum logic {
		OP_MAX = 1'b0,  // Signed maximum
		OP_AVG = 1'b1   // Sum, then arithmetic shift by win_log2
	} pool_op_e;

	// Per-window configuration, sampled with the first word of a window
	typedef struct packed {
		pool_op_e   op;
		logic [2:0] win_log2;  // 0 to MAX_WIN_LOG2
	} pool_cfg_t;

	// Sideband that travels with each atom to the lanes
	typedef struct packed {
		logic       first;     // Atom opens its window, lane reloads
		logic       last;      // Atom closes its window, lane registers a result
		pool_op_e   op;
		logic [2:0] win_log2;
	} atom_ctl_t;

endpackage

// ==== atom_deserializer.sv ====
`timescale 1ns/1ps

// Packs LANES input words into one atom and tags window position
module atom_deserializer #(
	parameter int LANES = 4
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic [pool_pkg::DATA_W-1:0]            i_in_data,
	input  logic                                   i_in_valid,
	input  pool_pkg::pool_cfg_t                    i_cfg,
	input  logic [LANES-1:0]                       i_lane_ready,
	output logic                                   o_in_ready,
	output logic [LANES-1:0][pool_pkg::DATA_W-1:0] o_atom_data,
	output pool_pkg::atom_ctl_t                    o_atom_ctl,
	output logic                                   o_atom_valid
);
	import pool_pkg::*;

	localparam int CNT_W = $clog2(LANES);

	logic [LANES-1:0][DATA_W-1:0] atom_q;  // Shift buffer, word 0 lands at index 0
	logic [CNT_W-1:0]             word_cnt;  // Words taken into the current atom
	logic [MAX_WIN_LOG2-1:0]      atom_cnt;  // Atoms finished in the current window
	logic [MAX_WIN_LOG2:0]        win_atoms;  // Atoms per window from latched cfg
	pool_cfg_t                    cfg_q;
	atom_ctl_t                    ctl_q;
	logic                         atom_valid_q;
	logic                         atom_take;
	logic                         word_acc;
	logic                         atom_done;
	logic                         win_start;
	logic                         last_atom;

	assign atom_take = atom_valid_q & (&i_lane_ready);  // All lanes in lockstep
	assign o_in_ready = ~atom_valid_q | atom_take;  // Stall only while an atom waits
	assign word_acc = i_in_valid & o_in_ready;
	assign atom_done = word_acc & (word_cnt == CNT_W'(LANES - 1));
	assign win_start = (word_cnt == '0) && (atom_cnt == '0);  // First word of a window

	assign win_atoms = (MAX_WIN_LOG2 + 1)'(1) << cfg_q.win_log2;
	assign last_atom = ({1'b0, atom_cnt} == win_atoms - 1'b1);

	// Counters and the valid flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt     <= '0;
			atom_cnt     <= '0;
			atom_valid_q <= 1'b0;
		end else begin
			if (atom_take)
				atom_valid_q <= 1'b0;
			if (word_acc) begin
				if (atom_done) begin
					word_cnt     <= '0;
					atom_valid_q <= 1'b1;  // Rises the cycle after the LANES-th word
					atom_cnt     <= last_atom ? '0 : atom_cnt + 1'b1;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	// Atom words, window config and sideband
	always_ff @(posedge clk) begin
		if (word_acc) begin
			atom_q <= {i_in_data, atom_q[LANES-1:1]};
			if (win_start)
				cfg_q <= i_cfg;  // Mid-window cfg changes are ignored
			if (atom_done) begin
				ctl_q.first    <= (atom_cnt == '0);
				ctl_q.last     <= last_atom;
				ctl_q.op       <= cfg_q.op;
				ctl_q.win_log2 <= cfg_q.win_log2;
			end
		end
	end

	// Buffer stays frozen while the atom is held
	assign o_atom_data  = atom_q;
	assign o_atom_ctl   = ctl_q;
	assign o_atom_valid = atom_valid_q;

endmodule

// ==== pool_lane.sv ====
`timescale 1ns/1ps

// One channel lane, reduces a window by signed max or floored average
module pool_lane (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [pool_pkg::DATA_W-1:0] i_atom_word,
	input  pool_pkg::atom_ctl_t         i_atom_ctl,
	input  logic                        i_atom_valid,
	input  logic                        i_take,
	output logic                        o_ready,
	output logic [pool_pkg::DATA_W-1:0] o_res_data,
	output logic                        o_res_valid
);
	import pool_pkg::*;

	logic signed [ACC_W-1:0] acc_q;  // Running max or running sum
	logic signed [ACC_W-1:0] acc_nxt;
	logic signed [ACC_W-1:0] word_ext;
	logic signed [ACC_W-1:0] avg_val;
	logic [DATA_W-1:0]       res_q;
	logic                    res_valid_q;
	logic                    atom_acc;

	assign word_ext = {{MAX_WIN_LOG2{i_atom_word[DATA_W-1]}}, i_atom_word};  // Sign extend
	assign atom_acc = i_atom_valid & o_ready;

	// Next accumulator value
	always_comb begin
		if (i_atom_ctl.first)
			acc_nxt = word_ext;  // Window opens, reload
		else if (i_atom_ctl.op == OP_MAX)
			acc_nxt = (word_ext > acc_q) ? word_ext : acc_q;
		else
			acc_nxt = acc_q + word_ext;
	end

	assign avg_val = acc_nxt >>> i_atom_ctl.win_log2;  // Arithmetic shift floors toward -inf

	always_ff @(posedge clk) begin
		if (atom_acc) begin
			acc_q <= acc_nxt;
			if (i_atom_ctl.last) begin
				// Max always fits DATA_W, average fits after the shift
				res_q <= (i_atom_ctl.op == OP_MAX) ? acc_nxt[DATA_W-1:0] : avg_val[DATA_W-1:0];
			end
		end
	end

	// Result handshake, accept and take never coincide
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			res_valid_q <= 1'b0;
		else if (atom_acc && i_atom_ctl.last)
			res_valid_q <= 1'b1;
		else if (i_take)
			res_valid_q <= 1'b0;
	end

	assign o_ready     = ~res_valid_q;  // Lane blocks while its result waits
	assign o_res_data  = res_q;
	assign o_res_valid = res_valid_q;

endmodule

// ==== result_serializer.sv ====
`timescale 1ns/1ps

// Collects one result per lane and emits them as a word stream, lane 0 first
module result_serializer #(
	parameter int LANES = 4
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic [LANES-1:0][pool_pkg::DATA_W-1:0] i_res_data,
	input  logic [LANES-1:0]                       i_res_valid,
	input  logic                                   i_out_ready,
	output logic                                   o_take,
	output logic [pool_pkg::DATA_W-1:0]            o_out_data,
	output logic                                   o_out_valid
);
	import pool_pkg::*;

	localparam int CNT_W = $clog2(LANES);

	logic [LANES-1:0][DATA_W-1:0] hold_q;  // Holding register, head word at index 0
	logic [CNT_W-1:0]             word_cnt;  // Words already sent from hold_q
	logic                         full_q;
	logic                         out_xfer;
	logic                         last_word;

	// Take only into an empty holding register
	assign o_take    = (&i_res_valid) & ~full_q;
	assign out_xfer  = full_q & i_out_ready;
	assign last_word = (word_cnt == CNT_W'(LANES - 1));

	// Control state
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full_q   <= 1'b0;
			word_cnt <= '0;
		end else if (o_take) begin
			full_q   <= 1'b1;  // Valid the cycle after the take
			word_cnt <= '0;
		end else if (out_xfer) begin
			if (last_word) begin
				full_q   <= 1'b0;  // Empty after the LANES-th word
				word_cnt <= '0;
			end else begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// Payload, shift down one lane per accepted word
	always_ff @(posedge clk) begin
		if (o_take)
			hold_q <= i_res_data;
		else if (out_xfer)
			hold_q <= hold_q >> DATA_W;
	end

	// Head word holds steady while i_out_ready is low
	assign o_out_data  = hold_q[0];
	assign o_out_valid = full_q;

endmodule

// ==== pool_engine.sv ====
`timescale 1ns/1ps

// Top level, deserializer then LANES pooling lanes then serializer
module pool_engine #(
	parameter int LANES = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [pool_pkg::DATA_W-1:0] i_in_data,
	input  logic                        i_in_valid,
	input  pool_pkg::pool_cfg_t         i_cfg,
	input  logic                        i_out_ready,
	output logic                        o_in_ready,
	output logic [pool_pkg::DATA_W-1:0] o_out_data,
	output logic                        o_out_valid
);
	import pool_pkg::*;

	// Deserializer to lanes
	logic [LANES-1:0][DATA_W-1:0] atom_data;
	atom_ctl_t                    atom_ctl;  // Shared by all lanes
	logic                         atom_valid;
	logic [LANES-1:0]             lane_ready;

	// Lanes to serializer
	logic [LANES-1:0][DATA_W-1:0] res_data;
	logic [LANES-1:0]             res_valid;
	logic                         res_take;  // One pulse clears every lane

	atom_deserializer #(
		.LANES(LANES)
	) u_deser (
		.clk         (clk),
		.rst         (rst),
		.i_in_data   (i_in_data),
		.i_in_valid  (i_in_valid),
		.i_cfg       (i_cfg),
		.i_lane_ready(lane_ready),
		.o_in_ready  (o_in_ready),
		.o_atom_data (atom_data),
		.o_atom_ctl  (atom_ctl),
		.o_atom_valid(atom_valid)
	);

	// One lane per channel, all in lockstep
	for (genvar g = 0; g < LANES; g++) begin : g_lane
		pool_lane u_lane (
			.clk         (clk),
			.rst         (rst),
			.i_atom_word (atom_data[g]),
			.i_atom_ctl  (atom_ctl),
			.i_atom_valid(atom_valid),
			.i_take      (res_take),
			.o_ready     (lane_ready[g]),
			.o_res_data  (res_data[g]),
			.o_res_valid (res_valid[g])
		);
	end

	result_serializer #(
		.LANES(LANES)
	) u_ser (
		.clk        (clk),
		.rst        (rst),
		.i_res_data (res_data),
		.i_res_valid(res_valid),
		.i_out_ready(i_out_ready),
		.o_take     (res_take),
		.o_out_data (o_out_data),
		.o_out_valid(o_out_valid)
	);

endmodule

// ==== pool_engine_assertions.sv ====
`timescale 1ns/1ps

// Stream protocol properties on the top-level ports
module pool_engine_assertions (
	input logic                        clk,
	input logic                        rst,
	input logic                        i_out_ready,
	input logic                        o_out_valid,
	input logic [pool_pkg::DATA_W-1:0] o_out_data,
	input logic                        o_in_ready
);
	int fail_cnt = 0;  // Failed property count

	// A stalled output word holds until it is taken
	property p_out_hold;
		@(posedge clk) disable iff (rst)
		(o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data));
	endproperty

	a_out_hold: assert property (p_out_hold)
		else begin
			fail_cnt++;
			$error("Output word or valid changed while the sink stalled");
		end

	// First cycle out of reset
	a_valid_after_rst: assert property (@(posedge clk) $fell(rst) |-> !o_out_valid)
		else begin
			fail_cnt++;
			$error("Output valid high in the cycle after reset");
		end

	a_ready_after_rst: assert property (@(posedge clk) $fell(rst) |-> o_in_ready)
		else begin
			fail_cnt++;
			$error("Input ready low in the cycle after reset");
		end

endmodule

bind pool_engine pool_engine_assertions u_assert (
	.clk        (clk),
	.rst        (rst),
	.i_out_ready(i_out_ready),
	.o_out_valid(o_out_valid),
	.o_out_data (o_out_data),
	.o_in_ready (o_in_ready)
);

// ==== tb_pool_engine.sv ====
`timescale 1ns/1ps

module tb_pool_engine;
	import pool_pkg::*;

	localparam int LANES   = 4;
	localparam int TIMEOUT = 4000;  // Cycles per wait

	logic              clk;
	logic              rst;
	logic [DATA_W-1:0] in_data;
	logic              in_valid;
	pool_cfg_t         cfg;
	logic              out_ready;
	logic              in_ready;
	logic [DATA_W-1:0] out_data;
	logic              out_valid;

	integer            seed;       // Source side stimulus
	integer            sink_seed;  // Separate stream for sink stalls
	int                gap_pct;    // Chance of idle cycles before a word
	int                stall_pct;  // Chance of out_ready low per cycle
	bit                scramble_cfg;  // Garbage cfg on non-first words
	logic [DATA_W-1:0] exp_q [$];  // Expected output words in order
	int                err_cnt;
	int                check_cnt;
	int                out_cnt;
	int                test_cnt;
	int                fail_tests;

	pool_engine #(
		.LANES(LANES)
	) dut0 (
		.clk        (clk),
		.rst        (rst),
		.i_in_data  (in_data),
		.i_in_valid (in_valid),
		.i_cfg      (cfg),
		.i_out_ready(out_ready),
		.o_in_ready (in_ready),
		.o_out_data (out_data),
		.o_out_valid(out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	function automatic bit chance(inout integer s, input int pct);
		int r;
		r = $unsigned($random(s)) % 100;
		return r < pct;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		check_cnt++;
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic timeout(input string what);
		$display("Timeout at %0d ns: %s", $time, what);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	// Sends one word on the input stream after optional idle cycles
	task automatic send_word(input logic [DATA_W-1:0] d, input pool_cfg_t c);
		int  waited;
		int  gaps;
		bit  taken;
		gaps = chance(seed, gap_pct) ? ($unsigned($random(seed)) % 4) + 1 : 0;
		in_valid = 1'b0;
		repeat (gaps) @(negedge clk);
		in_data  = d;
		cfg      = c;
		in_valid = 1'b1;
		waited   = 0;
		taken    = 1'b0;
		while (!taken) begin
			taken = in_ready;  // Driven from registers so steady until the rising edge
			@(negedge clk);
			waited++;
			if (!taken && waited > TIMEOUT)
				timeout("input stream never accepted a word");
		end
		in_valid = 1'b0;
	endtask

	// Builds a random window, queues its expected results and sends its words
	task automatic run_window(input pool_op_e op, input int wl2);
		logic [DATA_W-1:0] words [$];
		pool_cfg_t         wcfg;
		pool_cfg_t         junk;
		int                n_atoms;
		int                div;
		int                v;
		int                res;
		n_atoms = 1 << wl2;
		div     = 1 << wl2;
		for (int k = 0; k < n_atoms * LANES; k++)
			words.push_back(DATA_W'($random(seed)));
		for (int l = 0; l < LANES; l++) begin
			res = $signed(words[l]);  // Atom 0 of this lane
			for (int a = 1; a < n_atoms; a++) begin
				v = $signed(words[a * LANES + l]);
				if (op == OP_MAX)
					res = (v > res) ? v : res;
				else
					res = res + v;
			end
			if (op == OP_AVG) begin
				v   = res;
				res = v / div;  // Truncates toward zero
				if ((v % div != 0) && (v < 0))
					res = res - 1;  // Floor for negative sums
			end
			exp_q.push_back(res[DATA_W-1:0]);
		end
		wcfg.op       = op;
		wcfg.win_log2 = 3'(wl2);
		for (int k = 0; k < n_atoms * LANES; k++) begin
			junk.op       = ($random(seed) & 1) ? OP_AVG : OP_MAX;
			junk.win_log2 = 3'($unsigned($random(seed)) % 5);
			send_word(words[k], (k == 0 || !scramble_cfg) ? wcfg : junk);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);  // Monitor pops on falling edges
			waited++;
			if (exp_q.size() != 0 && waited > TIMEOUT)
				timeout("output stream stalled with results still outstanding");
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("Test %0d %s: ok", test_cnt, name);
		end else begin
			fail_tests++;
			$display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
		end
	endtask

	// Sink decides each transfer at the falling edge for the next rising edge
	always @(negedge clk) begin
		out_ready = !chance(sink_seed, stall_pct);
		if (!rst && out_valid && out_ready) begin
			out_cnt++;
			if (exp_q.size() == 0) begin
				$display("Output word %h appeared at %0d ns with no window outstanding",
					out_data, $time);
				err_cnt++;
			end else begin
				check_eq(out_data, exp_q.pop_front(), "pooled output word");
			end
		end
	end

	initial begin
		int       e0;
		int       outs_before;
		pool_op_e op;
		pool_cfg_t pcfg;
		seed         = 32'h8f26_0ba5;
		sink_seed    = seed ^ 32'h3c3c_c3c3;
		rst          = 1'b1;
		in_data      = '0;
		in_valid     = 1'b0;
		cfg          = '0;
		out_ready    = 1'b0;
		gap_pct      = 0;
		stall_pct    = 0;
		scramble_cfg = 1'b0;
		err_cnt      = 0;
		check_cnt    = 0;
		out_cnt      = 0;
		test_cnt     = 0;
		fail_tests   = 0;
		repeat (10) @(negedge clk);  // Power-on reset
		rst = 1'b0;

		e0 = err_cnt;
		for (int i = 0; i < 12; i++)
			run_window(OP_MAX, 2);
		wait_drain();
		finish_test("max pooling, 4-atom windows", e0);

		e0 = err_cnt;
		for (int i = 0; i < 8; i++) begin
			run_window(OP_AVG, 1);
			run_window(OP_AVG, 3);
		end
		wait_drain();
		finish_test("average pooling, 2- and 8-atom windows", e0);

		e0 = err_cnt;
		for (int i = 0; i < 6; i++) begin
			run_window(OP_MAX, 0);
			run_window(OP_AVG, 0);
		end
		wait_drain();
		finish_test("single-atom windows", e0);

		e0 = err_cnt;
		gap_pct      = 30;
		stall_pct    = 40;
		scramble_cfg = 1'b1;  // Mid-window cfg noise
		for (int i = 0; i < 40; i++) begin
			op = ($random(seed) & 1) ? OP_AVG : OP_MAX;
			run_window(op, $unsigned($random(seed)) % 5);
		end
		wait_drain();
		gap_pct      = 0;
		stall_pct    = 0;
		scramble_cfg = 1'b0;
		finish_test("gaps, stalls and changing config", e0);

		e0 = err_cnt;
		stall_pct     = 100;  // Sink blocked so results stay inside the DUT
		run_window(OP_MAX, 0);
		pcfg.op       = OP_AVG;
		pcfg.win_log2 = 3'd2;
		for (int k = 0; k < 6; k++)
			send_word(DATA_W'($random(seed)), pcfg);  // Partial window that yields no results
		apply_reset();
		exp_q.delete();  // Reset drops the held results
		stall_pct   = 0;
		outs_before = out_cnt;
		repeat (30) @(negedge clk);
		check_eq(out_cnt, outs_before, "output words after reset with no new window");
		run_window(OP_AVG, 2);
		run_window(OP_MAX, 1);
		wait_drain();
		finish_test("reset in mid-window", e0);

		check_eq(dut0.u_assert.fail_cnt, 0, "protocol assertion failures");
		$display("Tests %0d, failed tests %0d, checks %0d, errors %0d",
			test_cnt, fail_tests, check_cnt, err_cnt);
		if (err_cnt == 0 && fail_tests == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== pool_engine.f ====
pool_pkg.sv
atom_deserializer.sv
pool_lane.sv
result_serializer.sv
pool_engine.sv
pool_engine_assertions.sv
tb_pool_engine.sv

// ==== Bender.yml ====
package:
  name: pool_engine

sources:
  - pool_pkg.sv
  - atom_deserializer.sv
  - pool_lane.sv
  - result_serializer.sv
  - pool_engine.sv
  - target: test
    files:
      - pool_engine_assertions.sv
      - tb_pool_engine.sv
